// File: spectrum_pkg.sv
/*
 * Spectrum paging package
 * Memory layout constants, memory model codes and the CPU write byte
 * with its ULA and 7FFD decodings
 */

package spectrum_pkg;

	// ====================================================================
	// External RAM layout
	// ====================================================================
	localparam int RAM_ADDR_W = 25;                  // 32 MB SDRAM space
	localparam int BANK_W     = 6;                   // 16 KB banks, up to 1 MB

	localparam logic [2:0]        ROM_REGION  = 3'd5;  // ROM pages live here
	localparam logic [BANK_W-1:0] SCREEN_BANK = 6'd5;  // 4000-7FFF
	localparam logic [BANK_W-1:0] MID_BANK    = 6'd2;  // 8000-BFFF

	// Memory model codes as seen on mem_mode
	localparam logic [2:0] MODE_128    = 3'd0;  // 128K/+2
	localparam logic [2:0] MODE_P1024  = 3'd1;  // Pentagon 1024
	localparam logic [2:0] MODE_PF1024 = 3'd2;  // Profi 1024
	localparam logic [2:0] MODE_48     = 3'd3;
	localparam logic [2:0] MODE_PLUS3  = 3'd4;

	// ====================================================================
	// CPU write byte
	// ====================================================================
	typedef struct packed {
		logic [2:0] spare;
		logic       ear;
		logic       mic;
		logic [2:0] border;
	} ula_view_t;

	typedef struct packed {
		logic [1:0] ext;       // Pentagon 1024 bank bits
		logic       lock;
		logic       rom;
		logic       scr;       // Shadow screen select
		logic [2:0] ram_page;
	} p7ffd_view_t;

	// Same byte, decoded per target port
	typedef union packed {
		logic [7:0]  raw;
		ula_view_t   ula;
		p7ffd_view_t p7ffd;
	} cpu_data_t;

endpackage

// File: io_ports.sv
/*
 * I/O write tracker and ULA port
 * Turns the I/O write level into a one-cycle strobe and holds the
 * border colour, EAR and MIC bits written to port FE
 */

`timescale 1ns/100ps

module io_ports import spectrum_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] addr,
	input  cpu_data_t   cpu_dout,
	input  logic        m1_n,
	input  logic        iorq_n,
	input  logic        wr_n,
	output logic        io_wr_stb,
	output logic [2:0]  border_color,
	output logic        ear_out,
	output logic        mic_out
);

	logic io_wr;       // I/O write cycle in progress
	logic io_wr_prev;
	logic io_wr_rise;
	logic ula_sel;

	// Interrupt acknowledge also asserts IORQ, so M1 must be high
	assign io_wr      = ~iorq_n & ~wr_n & m1_n;
	assign io_wr_rise = io_wr & ~io_wr_prev;
	assign ula_sel    = ~addr[0];  // ULA decodes A0 only

	// ====================================================================
	// Write edge detection
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_prev <= 1'b0;
			io_wr_stb  <= 1'b0;
		end else begin
			io_wr_prev <= io_wr;
			io_wr_stb  <= io_wr_rise;  // One clock per bus write
		end
	end

	// ====================================================================
	// Port FE
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (io_wr_rise && ula_sel) begin
			ear_out <= cpu_dout.ula.ear;
			mic_out <= cpu_dout.ula.mic;
		end
	end

	// Border survives reset
	always_ff @(posedge clk_sys) begin
		if (io_wr_rise && ula_sel)
			border_color <= cpu_dout.ula.border;
	end

endmodule

// File: page_regs.sv
/*
 * Paging registers
 * Latches the memory model at reset, decodes the 7FFD, 1FFD, DFFD and
 * EFF7 ports and holds the paging state used by the RAM mapper
 */

`timescale 1ns/100ps

module page_regs import spectrum_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [2:0]  mem_mode,
	input  logic [15:0] addr,
	input  cpu_data_t   cpu_dout,
	input  logic        io_wr_stb,
	output logic [7:0]  page_reg,        // Last 7FFD value
	output logic [7:0]  page_reg_plus3,  // Last 1FFD value
	output logic [2:0]  page_128k,       // Upper bank bits for C000
	output logic        zx48,
	output logic        plus3,
	output logic        page_scr
);

	logic       p1024;
	logic       pf1024;
	logic [3:0] model_flags;  // {p1024, pf1024, zx48, plus3}
	logic       p1024_lock;   // EFF7 bit 2
	logic       page_disable;
	logic       sel_7ffd;
	logic       sel_1ffd;
	logic       sel_dffd;
	logic       sel_eff7;

	// ====================================================================
	// Model decode
	// ====================================================================
	always_comb begin
		case (mem_mode)
			MODE_128:    model_flags = 4'b0000;
			MODE_P1024:  model_flags = 4'b1000;
			MODE_PF1024: model_flags = 4'b0100;
			MODE_48:     model_flags = 4'b0010;
			MODE_PLUS3:  model_flags = 4'b0001;
			default:     model_flags = 4'b0000;  // Unknown codes act as 128K
		endcase
	end

	// ====================================================================
	// Port decode
	// ====================================================================
	// Pentagon 1024 honours the 7FFD lock only in its 128K compatible mode
	assign page_disable = zx48 | (~p1024 & page_reg[5]) | (p1024 & p1024_lock & page_reg[5]);

	// 7FFD is partially decoded, +3 also needs A14 to keep clear of 1FFD
	assign sel_7ffd = ~addr[15] & ~addr[1] & (addr[14] | ~plus3) & ~page_disable;
	assign sel_1ffd = plus3 & ~addr[15] & ~addr[14] & ~addr[13] & addr[12] & ~addr[1]
		& ~page_disable;
	assign sel_dffd = pf1024 & (addr == 16'hDFFD);
	assign sel_eff7 = p1024 & addr[15] & addr[14] & addr[13] & ~addr[12] & ~addr[3];

	assign page_scr = page_reg[3];

	// ====================================================================
	// Registers
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			{p1024, pf1024, zx48, plus3} <= model_flags;
			page_reg       <= '0;
			page_reg_plus3 <= '0;
			page_128k      <= '0;
			p1024_lock     <= 1'b0;
		end else if (io_wr_stb) begin
			if (sel_7ffd) begin
				page_reg <= cpu_dout.raw;
				// Bits 5, 7, 6 become bank bits 5, 4, 3
				if (p1024 && !p1024_lock)
					page_128k <= {cpu_dout.p7ffd.lock, cpu_dout.p7ffd.ext};
			end else if (sel_1ffd) begin
				page_reg_plus3 <= cpu_dout.raw;
			end

			if (sel_dffd)
				page_128k <= cpu_dout.raw[2:0];  // Profi high bank bits
			if (sel_eff7)
				p1024_lock <= cpu_dout.raw[2];
		end
	end

endmodule

// File: ram_mapper.sv
/*
 * RAM mapper
 * Forms the external RAM address and the read and write strobes from
 * the CPU address and the paging state
 */

`timescale 1ns/100ps

module ram_mapper import spectrum_pkg::*; (
	input  logic [15:0]           addr,
	input  logic                  mreq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic [7:0]            page_reg,
	input  logic [7:0]            page_reg_plus3,
	input  logic [2:0]            page_128k,
	input  logic                  zx48,
	input  logic                  plus3,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  ram_we,
	output logic                  ram_rd
);

	logic              special;     // +3 all-RAM mode
	logic [1:0]        special_map;
	logic [3:0]        rom_page;
	logic [11:0]       map_banks;   // Four 3-bit banks, C000 quarter on top
	logic [2:0]        special_bank;
	logic [BANK_W-1:0] bank;

	assign special     = plus3 & page_reg_plus3[0];
	assign special_map = page_reg_plus3[2:1];

	// ====================================================================
	// ROM page
	// ====================================================================
	always_comb begin
		if (plus3)
			rom_page = {2'b10, page_reg_plus3[2], page_reg[4]};  // Pages 8 to 11
		else
			rom_page = {3'b011, zx48 | page_reg[4]};  // 6 is 128 editor, 7 is 48 BASIC
	end

	// ====================================================================
	// +3 all-RAM maps
	// ====================================================================
	always_comb begin
		case (special_map)
			2'd0:    map_banks = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    map_banks = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    map_banks = {3'd3, 3'd6, 3'd5, 3'd4};
			default: map_banks = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
		special_bank = map_banks[addr[15:14]*3 +: 3];
	end

	// ====================================================================
	// Address
	// ====================================================================
	always_comb begin
		case (addr[15:14])
			2'd1:    bank = SCREEN_BANK;
			2'd2:    bank = MID_BANK;
			default: bank = {page_128k, page_reg[2:0]};  // Paged top quarter
		endcase

		if (special)
			ram_addr = RAM_ADDR_W'({BANK_W'(special_bank), addr[13:0]});
		else if (addr[15:14] == 2'd0)
			ram_addr = RAM_ADDR_W'({ROM_REGION, rom_page, addr[13:0]});
		else
			ram_addr = RAM_ADDR_W'({bank, addr[13:0]});
	end

	// ROM area is write protected unless it holds RAM
	assign ram_we = (special | addr[15] | addr[14]) & ~mreq_n & ~wr_n;
	assign ram_rd = ~mreq_n & ~rd_n;

endmodule

// File: spectrum_paging.sv
/*
 * Spectrum memory paging unit
 * Tracks I/O writes to the paging ports and the ULA port, and maps
 * the CPU address onto the external RAM
 */

`timescale 1ns/100ps

module spectrum_paging import spectrum_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [2:0]            mem_mode,
	input  logic [15:0]           addr,
	input  cpu_data_t             cpu_dout,
	input  logic                  m1_n,
	input  logic                  mreq_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  ram_we,
	output logic                  ram_rd,
	output logic                  page_scr,
	output logic [2:0]            border_color,
	output logic                  ear_out,
	output logic                  mic_out
);

	logic       io_wr_stb;
	logic [7:0] page_reg;
	logic [7:0] page_reg_plus3;
	logic [2:0] page_128k;
	logic       zx48;
	logic       plus3;

	io_ports u_io_ports (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.m1_n         (m1_n),
		.iorq_n       (iorq_n),
		.wr_n         (wr_n),
		.io_wr_stb    (io_wr_stb),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	page_regs u_page_regs (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.mem_mode       (mem_mode),
		.addr           (addr),
		.cpu_dout       (cpu_dout),
		.io_wr_stb      (io_wr_stb),
		.page_reg       (page_reg),
		.page_reg_plus3 (page_reg_plus3),
		.page_128k      (page_128k),
		.zx48           (zx48),
		.plus3          (plus3),
		.page_scr       (page_scr)
	);

	ram_mapper u_ram_mapper (
		.addr           (addr),
		.mreq_n         (mreq_n),
		.rd_n           (rd_n),
		.wr_n           (wr_n),
		.page_reg       (page_reg),
		.page_reg_plus3 (page_reg_plus3),
		.page_128k      (page_128k),
		.zx48           (zx48),
		.plus3          (plus3),
		.ram_addr       (ram_addr),
		.ram_we         (ram_we),
		.ram_rd         (ram_rd)
	);

endmodule

// File: tb_spectrum_paging.sv
/*
 * Testbench for the Spectrum paging unit
 * Replays bus operations from the vector file and checks the RAM
 * mapping and the ULA port outputs against the expected values
 */

`timescale 1ns/100ps

module tb_spectrum_paging import spectrum_pkg::*; ();

	localparam string VEC_FILE = "paging_vectors.txt";

	logic                  clk_sys = 1'b0;
	logic                  reset;
	logic [2:0]            mem_mode;
	logic [15:0]           addr;
	cpu_data_t             cpu_dout;
	logic                  m1_n;
	logic                  mreq_n;
	logic                  iorq_n;
	logic                  rd_n;
	logic                  wr_n;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  ram_we;
	logic                  ram_rd;
	logic                  page_scr;
	logic [2:0]            border_color;
	logic                  ear_out;
	logic                  mic_out;

	int errors      = 0;  // Mismatches in the current vector
	int n_pass      = 0;
	int n_fail      = 0;
	int cycles      = 0;
	int cycle_limit = 0;  // Set once the vector file is sized

	spectrum_paging u_spectrum_paging (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mem_mode     (mem_mode),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.m1_n         (m1_n),
		.mreq_n       (mreq_n),
		.iorq_n       (iorq_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.ram_addr     (ram_addr),
		.ram_we       (ram_we),
		.ram_rd       (ram_rd),
		.page_scr     (page_scr),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	always #50 clk_sys = ~clk_sys;  // 100 ns period

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the run went past %0d clock cycles", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	// ====================================================================
	// Compare tasks
	// ====================================================================
	task automatic check_ram_addr(input logic [RAM_ADDR_W-1:0] expected,
			input logic [RAM_ADDR_W-1:0] actual);
		if (actual !== expected) begin
			$display("Fail ram_addr: expected 0x%h, got 0x%h", expected, actual);
			errors++;
		end
	endtask

	task automatic check_we(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail ram_we: expected 0x%h, got 0x%h", expected, actual);
			errors++;
		end
	endtask

	task automatic check_rd(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail ram_rd: expected 0x%h, got 0x%h", expected, actual);
			errors++;
		end
	endtask

	task automatic check_scr(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail page_scr: expected 0x%h, got 0x%h", expected, actual);
			errors++;
		end
	endtask

	task automatic check_ula(input cpu_data_t expected, input cpu_data_t actual);
		if (actual.raw !== expected.raw) begin
			$display("Fail border_color/ear_out/mic_out: expected 0x%h, got 0x%h",
				expected.raw, actual.raw);
			errors++;
		end
	endtask

	// ====================================================================
	// Bus operations
	// ====================================================================
	task automatic apply_reset(input logic [2:0] mode);
		@(posedge clk_sys);
		reset    <= 1'b1;
		mem_mode <= mode;  // Model is latched while reset is high
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	task automatic io_write(input logic [15:0] port, input logic [7:0] data);
		@(posedge clk_sys);
		addr         <= port;
		cpu_dout.raw <= data;
		iorq_n       <= 1'b0;
		wr_n         <= 1'b0;
		repeat (3) @(posedge clk_sys);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic mem_access(input logic [15:0] a, input logic write,
			input logic [RAM_ADDR_W-1:0] exp_addr, input logic exp_we,
			input logic exp_scr);
		@(posedge clk_sys);
		addr   <= a;
		mreq_n <= 1'b0;
		rd_n   <= write;
		wr_n   <= ~write;
		@(posedge clk_sys);  // Mapping settled one cycle after the address
		check_ram_addr(exp_addr, ram_addr);
		check_we(exp_we, ram_we);
		check_rd(~write, ram_rd);  // Any read strobes ram_rd
		check_scr(exp_scr, page_scr);
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic sample_ula(input logic [2:0] border, input logic ear, input logic mic);
		cpu_data_t expected;
		cpu_data_t actual;
		@(posedge clk_sys);
		expected            = '0;
		expected.ula.border = border;
		expected.ula.ear    = ear;
		expected.ula.mic    = mic;
		actual              = '0;
		actual.ula.border   = border_color;
		actual.ula.ear      = ear_out;
		actual.ula.mic      = mic_out;
		check_ula(expected, actual);
	endtask

	// ====================================================================
	// Vector replay
	// ====================================================================
	initial begin
		int               fd;
		int               lines;
		int               n;
		int               want;
		int               vec;
		logic [8*128-1:0] text;
		logic [7:0]       op;
		logic [31:0]      v0;
		logic [31:0]      v1;
		logic [31:0]      v2;
		logic [31:0]      v3;
		logic [2:0]       cur_mode;
		logic [7:0]       exp_7ffd;   // Last 7FFD byte the unit accepted
		logic             eff7_bit2;
		logic             locked;

		reset     = 1'b1;
		mem_mode  = MODE_128;
		addr      = '0;
		cpu_dout  = '0;
		m1_n      = 1'b1;
		mreq_n    = 1'b1;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		lines     = 0;
		vec       = 0;
		cur_mode  = MODE_128;
		exp_7ffd  = '0;
		eff7_bit2 = 1'b0;

		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the vector file %s", VEC_FILE);
			$display("Regression failed");
		end else begin
			while ($fgets(text, fd) != 0)
				lines++;
			cycle_limit = 8 * lines + 100;
			$fclose(fd);
			fd = $fopen(VEC_FILE, "r");

			while ($fscanf(fd, " %c", op) == 1) begin
				if (op == "#") begin
					n = $fgets(text, fd);  // Skip comment line
				end else begin
					errors = 0;
					vec++;
					n      = 0;
					want   = 0;
					case (op)
						"R": begin
							want = 1;
							n    = $fscanf(fd, "%h", v0);
							apply_reset(v0[2:0]);
							cur_mode  = v0[2:0];
							exp_7ffd  = '0;
							eff7_bit2 = 1'b0;
						end
						"O": begin
							want = 2;
							n    = $fscanf(fd, "%h %h", v0, v1);
							io_write(v0[15:0], v1[7:0]);
							// Paging lock as seen before this write
							locked = (cur_mode == MODE_48) || (exp_7ffd[5]
								&& (cur_mode != MODE_P1024 || eff7_bit2));
							if (v0[15:0] == 16'h7FFD && !locked)
								exp_7ffd = v1[7:0];
							if (v0[15:0] == 16'hEFF7 && cur_mode == MODE_P1024)
								eff7_bit2 = v1[2];
						end
						"M": begin
							want = 4;
							n    = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
							mem_access(v0[15:0], v1[0], v2[RAM_ADDR_W-1:0], v3[0],
								exp_7ffd[3]);
						end
						"U": begin
							want = 3;
							n    = $fscanf(fd, "%h %h %h", v0, v1, v2);
							sample_ula(v0[2:0], v1[0], v2[0]);
						end
						default: begin
							$display("Vector %0d has an unknown operation code", vec);
							errors++;
						end
					endcase
					if (n != want) begin
						$display("Vector %0d has the wrong number of fields", vec);
						errors++;
					end
					if (errors == 0)
						n_pass++;
					else
						n_fail++;
					$display("Vector %0d op %c: %s", vec, op, (errors == 0) ? "ok" : "mismatch");
				end
			end
			$fclose(fd);

			$display("Vectors run %0d, passed %0d, failed %0d", vec, n_pass, n_fail);
			if (n_fail == 0 && vec > 0)
				$display("Regression passed");
			else
				$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: paging_vectors.txt
# R mode | O port data | M addr write ram_addr ram_we | U border ear mic
# All fields hex, write is 1 for a memory write and 0 for a read
R 0
M 0000 0 0158000 0
M 4000 0 0014000 0
M 8000 0 0008000 0
M C123 0 0000123 0
M 0000 1 0158000 0
O 7FFD 13
M C000 0 000C000 0
M 0000 0 015C000 0
O 7FFD 21
O 7FFD 07
M C000 0 0004000 0
M 0000 0 0158000 0
R 3
O 7FFD 03
M FFFF 0 0003FFF 0
M 3FFF 0 015FFFF 0
R 4
O 1FFD 04
M 0000 0 0168000 0
O 7FFD 10
M 0000 0 016C000 0
O 1FFD 01
M 0000 1 0000000 1
M 4000 0 0004000 0
M C000 0 000C000 0
R 1
O 7FFD E4
M C000 0 00F0000 0
O 7FFD C4
M C000 0 0070000 0
O EFF7 04
O 7FFD 02
M C000 0 0068000 0
R 2
O 7FFD 05
O DFFD 05
M E001 1 00B6001 1
O 00FE 1B
U 3 1 1
O 00FE 04
U 4 0 0
O 00FE 1A
R 0
U 2 0 0

// File: list.f
spectrum_pkg.sv
io_ports.sv
page_regs.sv
ram_mapper.sv
spectrum_paging.sv
tb_spectrum_paging.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the result
verilator --binary --timing --top-module tb_spectrum_paging -f list.f -o sim_paging \
	&& ./obj_dir/sim_paging > sim.log 2>&1 \
	|| { echo "Simulation did not build or run"; exit 1; }
grep -q "Regression passed" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }
